/* common/link_frame_pkg.sv */
`default_nettype none

package link_frame_pkg;

    localparam int PREAMBLE_PULSES = 8;
    localparam int INTERVALS = PREAMBLE_PULSES - 1;
    localparam int EDGE_CNT_W = $clog2(PREAMBLE_PULSES + 1);

    localparam int PACKET_BITS = 64;
    localparam int TX_PULSES = PREAMBLE_PULSES + PACKET_BITS;
    localparam int COUNT_W = $clog2(TX_PULSES + 1);

    localparam int CREDIT_INIT = 4; // bytes the consumer can take.
    localparam int CREDIT_W = 3;

    // msb is the earliest sample.
    typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

/* common/link_timing_pkg.sv */
`default_nettype none

package link_timing_pkg;

    localparam int TIMEOUT_CYCLES = 14000; // preamble gap limit.
    localparam int TX_PERIOD = 10000;      // transmit strobe spacing.

    localparam int CNT_W = 15;
    localparam int SUM_W = 18;             // seven intervals plus headroom.
    localparam int DIV_W = $clog2(SUM_W + 1);

    // controller states.
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [ST_W-1:0] ST_COLLECT = 3'd1;
    localparam logic [ST_W-1:0] ST_LOAD    = 3'd2;
    localparam logic [ST_W-1:0] ST_STROBE  = 3'd3;
    localparam logic [ST_W-1:0] ST_TX_WAIT = 3'd4;
    localparam logic [ST_W-1:0] ST_TX_RUN  = 3'd5;

endpackage

`default_nettype wire

/* common/strobe_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface strobe_if
    import link_timing_pkg::*, link_frame_pkg::*;
();

    logic               start;      // one cycle, loads period.
    logic               tx_mode;
    logic [CNT_W-1:0]   period;
    logic               half_first;
    logic               abort;      // level, stops the burst.

    logic               strobe;
    logic [COUNT_W-1:0] count;
    logic               done;       // with the last strobe.

    modport ctrl (
        output start, tx_mode, period, half_first, abort,
        input  strobe, count, done
    );

    modport gen (
        input  start, tx_mode, period, half_first, abort,
        output strobe, count, done
    );

endinterface

`default_nettype wire

/* link_ctrl/link_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module link_ctrl
    import link_timing_pkg::*, link_frame_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             rx_mode,
    input  wire             rf_edge,
    input  wire             tx_edge,
    input  wire [CNT_W-1:0] avg,
    input  wire             avg_valid,
    input  wire             timeout,
    output logic            meter_enable,
    output logic            meter_clear,
    output logic            fsm_rst,
    output logic            packer_clear,
    strobe_if.ctrl          sif
);

    logic [ST_W-1:0]  state;
    logic             start_q;
    logic             tx_mode_q;
    logic             half_first_q;
    logic [CNT_W-1:0] period_q;

    // meter runs only while a preamble may be arriving.
    assign meter_enable = rx_mode && (state == ST_IDLE || state == ST_COLLECT);

    // mode flip in mid-burst.
    assign sif.abort = (state == ST_STROBE && !rx_mode) || (state == ST_TX_RUN && rx_mode);

    // packer only listens while packet bits are being strobed.
    assign packer_clear = (state != ST_STROBE);

    assign sif.start      = start_q;
    assign sif.tx_mode    = tx_mode_q;
    assign sif.half_first = half_first_q;
    assign sif.period     = period_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= ST_IDLE;
            start_q      <= 1'b0;
            tx_mode_q    <= 1'b0;
            half_first_q <= 1'b0;
            fsm_rst      <= 1'b0;
            meter_clear  <= 1'b0;
        end else begin
            start_q     <= 1'b0;
            fsm_rst     <= 1'b0;
            meter_clear <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (!rx_mode) begin
                        state <= ST_TX_WAIT;
                    end else if (rf_edge) begin
                        fsm_rst <= 1'b1; // first preamble pulse.
                        state   <= ST_COLLECT;
                    end
                end

                ST_COLLECT: begin
                    if (!rx_mode) begin
                        meter_clear <= 1'b1;
                        state       <= ST_TX_WAIT;
                    end else if (timeout) begin
                        fsm_rst <= 1'b1;
                        state   <= ST_IDLE; // meter drops the preamble itself.
                    end else begin
                        if (rf_edge) begin
                            fsm_rst <= 1'b1;
                        end
                        if (avg_valid) begin
                            state <= ST_LOAD;
                        end
                    end
                end

                ST_LOAD: begin
                    if (!rx_mode) begin
                        meter_clear <= 1'b1;
                        state       <= ST_TX_WAIT;
                    end else begin
                        start_q      <= 1'b1;
                        half_first_q <= 1'b1;
                        tx_mode_q    <= 1'b0;
                        state        <= ST_STROBE;
                    end
                end

                ST_STROBE: begin
                    if (!rx_mode) begin
                        meter_clear <= 1'b1;
                        state       <= ST_TX_WAIT;
                    end else if (sif.done) begin
                        meter_clear <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end

                ST_TX_WAIT: begin
                    if (rx_mode) begin
                        state <= ST_IDLE;
                    end else if (tx_edge) begin
                        start_q      <= 1'b1;
                        half_first_q <= 1'b0;
                        tx_mode_q    <= 1'b1;
                        state        <= ST_TX_RUN;
                    end
                end

                ST_TX_RUN: begin
                    if (rx_mode || sif.done) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // period handed to the generator with start.
    always_ff @(posedge clk) begin
        if (state == ST_LOAD) begin
            period_q <= avg;
        end else if (state == ST_TX_WAIT && tx_edge) begin
            period_q <= CNT_W'(TX_PERIOD);
        end
    end

endmodule

`default_nettype wire

/* list.f */
common/link_timing_pkg.sv
common/link_frame_pkg.sv
common/strobe_if.sv
link_ctrl/link_ctrl.sv
logic/edge_sync.sv
logic/interval_meter.sv
logic/strobe_gen.sv
logic/sample_packer.sv
logic/pulse_link_top.sv
testbench/pulse_link_tb.sv

/* logic/edge_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module edge_sync (
    input  wire  clk,
    input  wire  rst,
    input  wire  din,
    output logic edge_pulse
);

    logic sync_1;
    logic sync_2;
    logic prev;

    // two flops against metastability, then a rise detector.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_1     <= 1'b0;
            sync_2     <= 1'b0;
            prev       <= 1'b0;
            edge_pulse <= 1'b0;
        end else begin
            sync_1     <= din;
            sync_2     <= sync_1;
            prev       <= sync_2;
            edge_pulse <= sync_2 && !prev; // 3 cycles after din rises.
        end
    end

endmodule

`default_nettype wire

/* logic/interval_meter.sv */
`timescale 1ns/1ns
`default_nettype none

module interval_meter
    import link_timing_pkg::*, link_frame_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              enable,
    input  wire              clear,
    input  wire              edge_pulse,
    output logic [CNT_W-1:0] avg,
    output logic             avg_valid,
    output logic             timeout
);

    logic [EDGE_CNT_W-1:0] edge_cnt;
    logic [CNT_W-1:0]      count;
    logic [SUM_W-1:0]      sum;
    logic [CNT_W-1:0]      tail_q;
    logic [2:0]            tail_r;
    logic [SUM_W-1:0]      div_q;
    logic [2:0]            div_r;
    logic [DIV_W-1:0]      div_step;
    logic                  collecting;
    logic                  take_edge;
    logic [3:0]            rem_shift;
    logic                  rem_ge;
    logic [3:0]            rem_sum;

    assign collecting = (edge_cnt != '0) && (edge_cnt < EDGE_CNT_W'(PREAMBLE_PULSES));
    assign take_edge  = enable && edge_pulse && (edge_cnt < EDGE_CNT_W'(PREAMBLE_PULSES));
    assign timeout    = enable && collecting && (count == CNT_W'(TIMEOUT_CYCLES));

    // restoring divide by seven, one quotient bit per cycle.
    assign rem_shift = {div_r, div_q[SUM_W-1]};
    assign rem_ge    = rem_shift >= 4'(INTERVALS);

    // remainders of the first six intervals and of the last one.
    assign rem_sum = {1'b0, div_r} + {1'b0, tail_r};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            edge_cnt  <= '0;
            count     <= '0;
            sum       <= '0;
            tail_q    <= '0;
            tail_r    <= '0;
            div_step  <= '0;
            avg_valid <= 1'b0;
        end else if (clear || timeout) begin
            edge_cnt  <= '0;
            count     <= '0;
            sum       <= '0;
            tail_q    <= '0;
            tail_r    <= '0;
            div_step  <= '0;
            avg_valid <= 1'b0;
        end else begin
            if (div_step != '0) begin
                div_step <= div_step - 1'b1;
            end
            if (take_edge) begin
                edge_cnt <= edge_cnt + 1'b1;
                count    <= CNT_W'(1);
                tail_q   <= '0;
                tail_r   <= 3'd1;
                if (edge_cnt != '0) begin
                    sum <= sum + SUM_W'(count);
                end
                if (edge_cnt == EDGE_CNT_W'(PREAMBLE_PULSES - 2)) begin
                    div_step <= DIV_W'(SUM_W); // six intervals are in.
                end
                if (edge_cnt == EDGE_CNT_W'(PREAMBLE_PULSES - 1)) begin
                    avg_valid <= 1'b1;
                end
            end else if (enable && collecting) begin
                count <= count + 1'b1;
                // last interval kept as count/7 and count%7.
                if (tail_r == 3'(INTERVALS - 1)) begin
                    tail_r <= '0;
                    tail_q <= tail_q + 1'b1;
                end else begin
                    tail_r <= tail_r + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_edge && edge_cnt == EDGE_CNT_W'(PREAMBLE_PULSES - 2)) begin
            div_q <= sum + SUM_W'(count);
            div_r <= '0;
        end else if (div_step != '0) begin
            div_q <= {div_q[SUM_W-2:0], rem_ge};
            div_r <= rem_ge ? 3'(rem_shift - 4'(INTERVALS)) : rem_shift[2:0];
        end
        if (take_edge && edge_cnt == EDGE_CNT_W'(PREAMBLE_PULSES - 1)) begin
            avg <= CNT_W'(div_q) + tail_q + CNT_W'(rem_sum >= 4'(INTERVALS));
        end
    end

endmodule

`default_nettype wire

/* logic/pulse_link_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_link_top
    import link_timing_pkg::*, link_frame_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   rfin,
    input  wire   rx_mode,
    input  wire   rx_bit,
    input  wire   tx_rdy,
    input  wire   credit_return,
    output logic  sh_en,
    output logic  fsm_rst,
    output byte_t byte_data,
    output logic  byte_valid,
    output logic  overrun
);

    logic             rf_edge;
    logic             tx_edge;
    logic [CNT_W-1:0] avg;
    logic             avg_valid;
    logic             timeout;
    logic             meter_enable;
    logic             meter_clear;
    logic             packer_clear;

    strobe_if sif ();

    edge_sync u_rf_sync (
        .clk        (clk),
        .rst        (rst),
        .din        (rfin),
        .edge_pulse (rf_edge)
    );

    edge_sync u_tx_sync (
        .clk        (clk),
        .rst        (rst),
        .din        (tx_rdy),
        .edge_pulse (tx_edge)
    );

    interval_meter u_meter (
        .clk        (clk),
        .rst        (rst),
        .enable     (meter_enable),
        .clear      (meter_clear),
        .edge_pulse (rf_edge),
        .avg        (avg),
        .avg_valid  (avg_valid),
        .timeout    (timeout)
    );

    link_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rx_mode      (rx_mode),
        .rf_edge      (rf_edge),
        .tx_edge      (tx_edge),
        .avg          (avg),
        .avg_valid    (avg_valid),
        .timeout      (timeout),
        .meter_enable (meter_enable),
        .meter_clear  (meter_clear),
        .fsm_rst      (fsm_rst),
        .packer_clear (packer_clear),
        .sif          (sif.ctrl)
    );

    strobe_gen u_gen (
        .clk   (clk),
        .rst   (rst),
        .sif   (sif.gen),
        .sh_en (sh_en)
    );

    sample_packer u_packer (
        .clk           (clk),
        .rst           (rst),
        .clear         (packer_clear),
        .strobe        (sif.strobe),
        .rx_bit        (rx_bit),
        .credit_return (credit_return),
        .byte_data     (byte_data),
        .byte_valid    (byte_valid),
        .overrun       (overrun)
    );

endmodule

`default_nettype wire

/* logic/sample_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_packer
    import link_frame_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    input  wire   clear,
    input  wire   strobe,
    input  wire   rx_bit,
    input  wire   credit_return,
    output byte_t byte_data,
    output logic  byte_valid,
    output logic  overrun
);

    logic [6:0]          shift_q;
    logic [2:0]          bit_cnt;
    byte_t               pend_data;
    byte_t               next_byte;
    logic                pending;
    logic [CREDIT_W-1:0] credits;
    logic                send;
    logic                byte_done;
    logic                credit_add;
    logic                load_pend;

    assign next_byte  = {shift_q, rx_bit};
    assign byte_done  = strobe && !clear && (bit_cnt == 3'd7);
    assign send       = pending && (credits != '0);
    assign credit_add = credit_return && (credits < CREDIT_W'(CREDIT_INIT));
    assign load_pend  = byte_done && (!pending || send); // slot free this cycle.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt    <= '0;
            pending    <= 1'b0;
            credits    <= CREDIT_W'(CREDIT_INIT);
            byte_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            byte_valid <= send;
            if (clear) begin
                bit_cnt <= '0;
            end else if (strobe) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            if (load_pend) begin
                pending <= 1'b1;
            end else if (send) begin
                pending <= 1'b0;
            end
            if (byte_done && !load_pend) begin
                overrun <= 1'b1; // new byte lost, sticky.
            end

            case ({send, credit_add})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (strobe && !clear) begin
            shift_q <= next_byte[6:0];
        end
        if (load_pend) begin
            pend_data <= next_byte;
        end
        if (send) begin
            byte_data <= pend_data;
        end
    end

endmodule

`default_nettype wire

/* logic/strobe_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module strobe_gen
    import link_timing_pkg::*, link_frame_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    strobe_if.gen sif,
    output logic  sh_en
);

    logic [CNT_W-1:0]   period_q;
    logic [CNT_W-1:0]   cnt;
    logic [CNT_W-1:0]   first_len;
    logic [COUNT_W-1:0] count_q;
    logic [COUNT_W-1:0] total;
    logic               active;
    logic               tx_q;
    logic               strobe_q;
    logic               done_q;
    logic               last;

    assign first_len = sif.half_first ? (sif.period >> 1) : sif.period;
    assign total     = tx_q ? COUNT_W'(TX_PULSES) : COUNT_W'(PACKET_BITS);
    assign last      = count_q == total - 1'b1;

    assign sif.strobe = strobe_q;
    assign sif.done   = done_q;
    assign sif.count  = count_q;
    assign sh_en      = strobe_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt      <= '0;
            count_q  <= '0;
            active   <= 1'b0;
            tx_q     <= 1'b0;
            strobe_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            done_q   <= 1'b0;
            if (sif.abort) begin
                active  <= 1'b0;
                cnt     <= '0;
                count_q <= '0;
            end else if (sif.start) begin
                cnt     <= first_len - 1'b1; // strobe lands first_len after start.
                count_q <= '0;
                tx_q    <= sif.tx_mode;
                active  <= 1'b1;
            end else if (active) begin
                if (cnt <= CNT_W'(1)) begin
                    strobe_q <= 1'b1;
                    cnt      <= period_q;
                    count_q  <= count_q + 1'b1;
                    if (last) begin
                        done_q <= 1'b1;
                        active <= 1'b0;
                    end
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sif.start) begin
            period_q <= sif.period;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module pulse_link_tb -o pulse_link_sim
./obj_dir/pulse_link_sim

/* testbench/pulse_link_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_link_tb
    import link_timing_pkg::*, link_frame_pkg::*;
;

    localparam int FSM_LAT = 5; // rfin rise to sampled fsm_rst.
    localparam int PULSE_W = 20;

    logic  clk = 1'b0;
    logic  rst;
    logic  rfin;
    logic  rx_mode;
    logic  rx_bit;
    logic  tx_rdy;
    logic  credit_return = 1'b0;
    logic  sh_en;
    logic  fsm_rst;
    byte_t byte_data;
    logic  byte_valid;
    logic  overrun;

    // monitor counters.
    int cyc = 0;
    int strobe_total = 0;
    int last_strobe = 0;
    int byte_total = 0;
    int fsm_total = 0;

    // check controls.
    logic  gap_on = 1'b0;
    int    gap_base = 0;
    int    exp_gap = 0;
    logic  align_on = 1'b0;
    int    rise_cyc = -100;
    logic  data_on = 1'b0;
    int    data_base = 0;
    logic  overrun_ok = 1'b0;
    logic  credit_auto = 1'b0;
    logic  credit_req = 1'b0;
    byte_t exp_bytes [8];
    logic  bits [64];
    int    spacing [8];

    pulse_link_top DUT (
        .clk           (clk),
        .rst           (rst),
        .rfin          (rfin),
        .rx_mode       (rx_mode),
        .rx_bit        (rx_bit),
        .tx_rdy        (tx_rdy),
        .credit_return (credit_return),
        .sh_en         (sh_en),
        .fsm_rst       (fsm_rst),
        .byte_data     (byte_data),
        .byte_valid    (byte_valid),
        .overrun       (overrun)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (sh_en) begin
            strobe_total <= strobe_total + 1;
            last_strobe  <= cyc;
        end
        if (byte_valid) begin
            byte_total <= byte_total + 1;
        end
        if (fsm_rst) begin
            fsm_total <= fsm_total + 1;
        end
        credit_return <= (credit_auto && byte_valid) || credit_req; // consumer side.
    end

    task automatic fail_text(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input int got, input int exp);
        fail_text($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    assert property (@(posedge clk) !rst |-> !(sh_en || fsm_rst || byte_valid || overrun))
        else fail_text("outputs not low during reset");

    assert property (@(posedge clk)
        (sh_en && gap_on && strobe_total > gap_base) |-> (cyc - last_strobe == exp_gap))
        else fail_value("sh_en gap", cyc - last_strobe, exp_gap);

    // one fsm_rst per preamble edge, nothing in between.
    assert property (@(posedge clk) align_on |-> (fsm_rst == (cyc - rise_cyc == FSM_LAT)))
        else fail_value("fsm_rst", int'(fsm_rst), int'(cyc - rise_cyc == FSM_LAT));

    assert property (@(posedge clk)
        (byte_valid && data_on) |-> (byte_data == exp_bytes[byte_total - data_base]))
        else fail_value("byte_data", int'(byte_data), int'(exp_bytes[byte_total - data_base]));

    assert property (@(posedge clk) !overrun_ok |-> !overrun)
        else fail_value("overrun", int'(overrun), 0);

    task automatic wait_strobe(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (sh_en !== 1'b1) begin
            n = n + 1;
            if (n > limit) begin
                fail_text("timeout waiting for sh_en");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_bytes(input int target, input int limit);
        int n;
        n = 0;
        while (byte_total < target) begin
            n = n + 1;
            if (n > limit) begin
                fail_text("timeout waiting for byte_valid");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_fsm(input int target, input int limit);
        int n;
        n = 0;
        while (fsm_total < target) begin
            n = n + 1;
            if (n > limit) begin
                fail_text("timeout waiting for fsm_rst");
            end
            @(posedge clk);
        end
    endtask

    // pulses on rfin, spacing[i] cycles between rises.
    task automatic drive_preamble(input int pulses);
        @(posedge clk);
        for (int i = 0; i < pulses; i++) begin
            rfin <= 1'b1;
            rise_cyc = cyc;
            repeat (PULSE_W) @(posedge clk);
            rfin <= 1'b0;
            if (i < pulses - 1) begin
                repeat (spacing[i] - PULSE_W) @(posedge clk);
            end
        end
    endtask

    task automatic pick_spacings();
        for (int i = 0; i < 8; i++) begin
            spacing[i] = 280 + int'($urandom % 41);
        end
    endtask

    // full preamble and 64 strobes, rx_bit moved between strobes.
    task automatic run_rx_burst(input logic check_data);
        int sum;
        sum = 0;
        pick_spacings();
        for (int i = 0; i < PREAMBLE_PULSES - 1; i++) begin
            sum = sum + spacing[i];
        end
        for (int k = 0; k < PACKET_BITS; k++) begin
            bits[k] = logic'($urandom % 2);
        end
        for (int j = 0; j < 8; j++) begin
            exp_bytes[j] = '0;
            for (int b = 0; b < 8; b++) begin
                exp_bytes[j] = {exp_bytes[j][6:0], bits[8 * j + b]}; // msb first.
            end
        end
        @(posedge clk);
        rx_bit <= bits[0];
        exp_gap = sum / 7;
        gap_base = strobe_total;
        gap_on = 1'b1;
        data_base = byte_total;
        data_on = check_data;
        align_on = 1'b1;
        drive_preamble(PREAMBLE_PULSES);
        align_on = 1'b0;
        for (int k = 0; k < PACKET_BITS; k++) begin
            wait_strobe(2000);
            if (k < PACKET_BITS - 1) begin
                repeat (exp_gap / 2) @(posedge clk);
                rx_bit <= bits[k + 1];
            end
        end
        repeat (2 * exp_gap) @(posedge clk);
        assert (strobe_total - gap_base == PACKET_BITS)
            else fail_value("sh_en count", strobe_total - gap_base, PACKET_BITS);
    endtask

    initial begin
        int base;
        void'($urandom(39696));
        rst <= 1'b0;
        rfin <= 1'b0;
        rx_mode <= 1'b1;
        rx_bit <= 1'b0;
        tx_rdy <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        assert (!(sh_en || fsm_rst || byte_valid || overrun))
            else fail_text("outputs not low after reset");

        // receive with credits flowing back.
        credit_auto <= 1'b1;
        run_rx_burst(1'b1);
        wait_bytes(data_base + 8, 5000);
        repeat (10) @(posedge clk);
        assert (byte_total - data_base == 8)
            else fail_value("byte_valid count", byte_total - data_base, 8);

        // no credits returned.
        credit_auto <= 1'b0;
        overrun_ok = 1'b1;
        run_rx_burst(1'b1);
        assert (byte_total - data_base == CREDIT_INIT)
            else fail_value("byte_valid count", byte_total - data_base, CREDIT_INIT);
        assert (overrun)
            else fail_value("overrun", int'(overrun), 1);
        credit_req <= 1'b1;
        @(posedge clk);
        credit_req <= 1'b0;
        wait_bytes(data_base + CREDIT_INIT + 1, 100);
        repeat (20) @(posedge clk);
        assert (byte_total - data_base == CREDIT_INIT + 1)
            else fail_value("byte_valid count", byte_total - data_base, CREDIT_INIT + 1);
        data_on = 1'b0;

        // broken preamble, then a good one.
        pick_spacings();
        base = fsm_total;
        gap_base = strobe_total;
        drive_preamble(3);
        wait_fsm(base + 4, TIMEOUT_CYCLES + 2000);
        repeat (100) @(posedge clk);
        assert (fsm_total == base + 4)
            else fail_value("fsm_rst count", fsm_total - base, 4);
        assert (strobe_total == gap_base)
            else fail_value("sh_en count", strobe_total - gap_base, 0);
        run_rx_burst(1'b0);

        // transmit burst.
        exp_gap = TX_PERIOD;
        gap_base = strobe_total;
        rx_mode <= 1'b0;
        repeat (5) @(posedge clk);
        tx_rdy <= 1'b1;
        for (int k = 0; k < TX_PULSES; k++) begin
            wait_strobe(TX_PERIOD + 2000);
        end
        repeat (2 * TX_PERIOD) @(posedge clk);
        assert (strobe_total - gap_base == TX_PULSES)
            else fail_value("sh_en count", strobe_total - gap_base, TX_PULSES);

        // second burst cut short by rx_mode.
        tx_rdy <= 1'b0;
        repeat (10) @(posedge clk);
        gap_base = strobe_total;
        tx_rdy <= 1'b1;
        for (int k = 0; k < 5; k++) begin
            wait_strobe(TX_PERIOD + 2000);
        end
        rx_mode <= 1'b1;
        repeat (3 * TX_PERIOD) @(posedge clk);
        assert (strobe_total - gap_base == 5)
            else fail_value("sh_en count", strobe_total - gap_base, 5);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
